/* source/scr_cfg.svh */
// screen controller config, active area, button regions, marker square and frame width
`ifndef SCR_CFG_SVH
`define SCR_CFG_SVH

// pixel counter width, covers 1024x768 plus blanking
`define SCR_CNT_W 11

// active area
`define SCR_H_ACT 1024
`define SCR_V_ACT 768

// all three menu buttons share one column, bounds inclusive
`define BTN_X_MIN 362
`define BTN_X_MAX 674

`define DIFF_Y_MIN 238   // difficulty toggle
`define DIFF_Y_MAX 338
`define THEME_Y_MIN 430  // theme step
`define THEME_Y_MAX 530
`define CRED_Y_MIN 622   // go to credits
`define CRED_Y_MAX 722

// difficulty marker, left of the difficulty button
`define MARK_X_MIN 300
`define MARK_X_MAX 340
`define MARK_Y_MIN 268
`define MARK_Y_MAX 308

// credits border thickness in pixels
`define FRAME_W 8

`endif

/* source/scr_pkg.sv */
// screen controller types for colour, active screen and theme index
`default_nettype none

package scr_pkg;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // which renderer drives the output
    typedef enum logic {
        SCR_MENU    = 1'b0,
        SCR_CREDITS = 1'b1
    } screen_e;

    // palette index, only 0..6 used
    typedef logic [2:0] theme_t;

endpackage

`default_nettype wire

/* source/menu_render.sv */
// menu renderer, draws three buttons and the difficulty marker over the theme background
`timescale 1ns/1ps
`default_nettype none
`include "scr_cfg.svh"

module menu_render (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [`SCR_CNT_W-1:0] hcount,
    input  wire [`SCR_CNT_W-1:0] vcount,
    input  wire                  hsync,
    input  wire                  vsync,
    input  wire                  hblnk,
    input  wire                  vblnk,
    input  wire                  difficulty,  // 1 lights the marker
    input  wire scr_pkg::rgb_t   color1,      // background
    input  wire scr_pkg::rgb_t   color2,      // buttons and lit marker
    output scr_pkg::rgb_t        rgb,
    output logic                 hsync_out,
    output logic                 vsync_out
);

    logic          in_col;    // shared button column
    logic          in_diff;
    logic          in_theme;
    logic          in_cred;
    logic          in_mark;
    scr_pkg::rgb_t rgb_nxt;

    assign in_col = (hcount >= `BTN_X_MIN) && (hcount <= `BTN_X_MAX);

    assign in_diff  = in_col && (vcount >= `DIFF_Y_MIN) && (vcount <= `DIFF_Y_MAX);
    assign in_theme = in_col && (vcount >= `THEME_Y_MIN) && (vcount <= `THEME_Y_MAX);
    assign in_cred  = in_col && (vcount >= `CRED_Y_MIN) && (vcount <= `CRED_Y_MAX);

    // marker square sits left of the button column, no overlap
    assign in_mark = (hcount >= `MARK_X_MIN) && (hcount <= `MARK_X_MAX) &&
                     (vcount >= `MARK_Y_MIN) && (vcount <= `MARK_Y_MAX);

    // pixel colour, blanking wins
    always_comb begin
        if (hblnk || vblnk) begin
            rgb_nxt = '0;                   // black outside active area
        end else if (in_diff || in_theme || in_cred) begin
            rgb_nxt = color2;
        end else if (in_mark && difficulty) begin
            rgb_nxt = color2;               // hard mode
        end else begin
            rgb_nxt = color1;               // background, unlit marker too
        end
    end

    // one stage, syncs travel with the pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb       <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            rgb       <= rgb_nxt;
            hsync_out <= hsync;
            vsync_out <= vsync;
        end
    end

    // blanked input pixel must come out black on the next cycle
    a_blank_black : assert property (
        @(posedge clk) disable iff (rst)
        (hblnk || vblnk) |=> (rgb == '0)
    ) else $error("menu_render: non-zero rgb after blanking");

endmodule

`default_nettype wire

/* source/cred_render.sv */
// credits renderer, draws a bordered panel across the active area
`timescale 1ns/1ps
`default_nettype none
`include "scr_cfg.svh"

module cred_render (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [`SCR_CNT_W-1:0] hcount,
    input  wire [`SCR_CNT_W-1:0] vcount,
    input  wire                  hsync,
    input  wire                  vsync,
    input  wire                  hblnk,
    input  wire                  vblnk,
    input  wire scr_pkg::rgb_t   color1,   // panel interior
    input  wire scr_pkg::rgb_t   color2,   // frame
    output scr_pkg::rgb_t        rgb,
    output logic                 hsync_out,
    output logic                 vsync_out
);

    logic          on_frame;
    scr_pkg::rgb_t rgb_nxt;

    // FRAME_W pixels in from each edge of the active area
    assign on_frame = (hcount < `FRAME_W) ||
                      (hcount >= `SCR_H_ACT - `FRAME_W) ||
                      (vcount < `FRAME_W) ||
                      (vcount >= `SCR_V_ACT - `FRAME_W);

    always_comb begin
        if (hblnk || vblnk) begin
            rgb_nxt = '0;
        end else if (on_frame) begin
            rgb_nxt = color2;
        end else begin
            rgb_nxt = color1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb       <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            rgb       <= rgb_nxt;
            hsync_out <= hsync;   // same delay as rgb
            vsync_out <= vsync;
        end
    end

    // blanked pixels stay black through the stage
    a_blank_black : assert property (
        @(posedge clk) disable iff (rst)
        (hblnk || vblnk) |=> (rgb == '0)
    ) else $error("cred_render: non-zero rgb after blanking");

endmodule

`default_nettype wire

/* source/screen_ctl.sv */
// screen controller top, menu/credits FSM with difficulty, theme palette and output register
`timescale 1ns/1ps
`default_nettype none
`include "scr_cfg.svh"

module screen_ctl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [`SCR_CNT_W-1:0] hcount,
    input  wire [`SCR_CNT_W-1:0] vcount,
    input  wire                  hsync,
    input  wire                  vsync,
    input  wire                  hblnk,
    input  wire                  vblnk,
    input  wire [11:0]           xpos,        // mouse pointer
    input  wire [11:0]           ypos,
    input  wire                  mouse_left,  // level, high = click this cycle
    input  wire                  button,      // back to menu
    output scr_pkg::rgb_t        rgb_out,
    output logic                 hsync_out,
    output logic                 vsync_out
);

    localparam scr_pkg::theme_t THEME_LAST = 3'd6;

    scr_pkg::screen_e state;
    scr_pkg::screen_e state_nxt;
    logic             difficulty;
    logic             difficulty_nxt;
    scr_pkg::theme_t  theme;
    scr_pkg::theme_t  theme_nxt;

    scr_pkg::rgb_t    color1;
    scr_pkg::rgb_t    color2;

    scr_pkg::rgb_t    rgb_menu;
    scr_pkg::rgb_t    rgb_cred;
    logic             hsync_menu;
    logic             vsync_menu;
    logic             hsync_cred;
    logic             vsync_cred;

    scr_pkg::rgb_t    rgb_sel;
    logic             hsync_sel;
    logic             vsync_sel;

    logic             in_col;
    logic             click_diff;
    logic             click_theme;
    logic             click_cred;

    // pointer hit tests, gated by the click
    assign in_col = (xpos >= `BTN_X_MIN) && (xpos <= `BTN_X_MAX);

    assign click_diff  = mouse_left && in_col &&
                         (ypos >= `DIFF_Y_MIN) && (ypos <= `DIFF_Y_MAX);
    assign click_theme = mouse_left && in_col &&
                         (ypos >= `THEME_Y_MIN) && (ypos <= `THEME_Y_MAX);
    assign click_cred  = mouse_left && in_col &&
                         (ypos >= `CRED_Y_MIN) && (ypos <= `CRED_Y_MAX);

    // next state, difficulty and theme
    always_comb begin
        state_nxt      = state;
        difficulty_nxt = difficulty;
        theme_nxt      = theme;
        case (state)
            scr_pkg::SCR_MENU: begin
                if (click_cred) begin
                    state_nxt = scr_pkg::SCR_CREDITS;
                end
                if (click_diff) begin
                    difficulty_nxt = !difficulty;
                end
                if (click_theme) begin
                    theme_nxt = (theme == THEME_LAST) ? '0 : theme + 3'd1;  // wrap 6 -> 0
                end
            end
            scr_pkg::SCR_CREDITS: begin
                if (button) begin
                    state_nxt = scr_pkg::SCR_MENU;   // clicks ignored here
                end
            end
            default: state_nxt = scr_pkg::SCR_MENU;
        endcase
    end

    // palette, dark background with a light accent
    always_comb begin
        case (theme)
            3'd0: begin color1 = 12'h000; color2 = 12'hFFF; end
            3'd1: begin color1 = 12'h099; color2 = 12'hF66; end
            3'd2: begin color1 = 12'h909; color2 = 12'h6F6; end
            3'd3: begin color1 = 12'h990; color2 = 12'h66F; end
            3'd4: begin color1 = 12'h009; color2 = 12'hFF6; end
            3'd5: begin color1 = 12'h900; color2 = 12'h6FF; end
            3'd6: begin color1 = 12'h090; color2 = 12'hF6F; end
            default: begin
                color1 = 12'h000;
                color2 = 12'hFFF;
            end
        endcase
    end

    menu_render menu0 (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .difficulty (difficulty),
        .color1     (color1),
        .color2     (color2),
        .rgb        (rgb_menu),
        .hsync_out  (hsync_menu),
        .vsync_out  (vsync_menu)
    );

    cred_render cred0 (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .color1     (color1),
        .color2     (color2),
        .rgb        (rgb_cred),
        .hsync_out  (hsync_cred),
        .vsync_out  (vsync_cred)
    );

    // select on registered state, one cycle after the switch
    always_comb begin
        if (state == scr_pkg::SCR_CREDITS) begin
            rgb_sel   = rgb_cred;
            hsync_sel = hsync_cred;
            vsync_sel = vsync_cred;
        end else begin
            rgb_sel   = rgb_menu;
            hsync_sel = hsync_menu;
            vsync_sel = vsync_menu;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= scr_pkg::SCR_MENU;
            difficulty <= 1'b0;
            theme      <= '0;
            rgb_out    <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
        end else begin
            state      <= state_nxt;
            difficulty <= difficulty_nxt;
            theme      <= theme_nxt;
            rgb_out    <= rgb_sel;     // second pipeline stage
            hsync_out  <= hsync_sel;
            vsync_out  <= vsync_sel;
        end
    end

    // palette has seven entries only
    a_theme_range : assert property (
        @(posedge clk) disable iff (rst)
        theme <= THEME_LAST
    ) else $error("screen_ctl: theme index out of range");

    // settings frozen while credits are shown
    a_cred_frozen : assert property (
        @(posedge clk) disable iff (rst)
        (state == scr_pkg::SCR_CREDITS) |=> ($stable(difficulty) && $stable(theme))
    ) else $error("screen_ctl: settings changed on credits screen");

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
// testbench clock and reset source, 20 ns clock with a 3 cycle synchronous reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 50 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;            // released just after the third edge
    end

endmodule

`default_nettype wire

/* verif/screen_tb.sv */
// screen controller testbench that checks a table of pixels and clicks against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "scr_cfg.svh"

module screen_tb;

    typedef struct {
        logic [`SCR_CNT_W-1:0] h, v;
        logic                  hs, vs, hb, vb;
        logic [11:0]           x, y;
        logic                  click, btn;
        scr_pkg::rgb_t         exp_rgb;   // colour expected 2 cycles later
    } step_t;

    logic                  clk, rst;
    logic [`SCR_CNT_W-1:0] hcount, vcount;
    logic                  hsync, vsync, hblnk, vblnk;
    logic [11:0]           xpos, ypos;
    logic                  mouse_left, button;
    scr_pkg::rgb_t         rgb_out;
    logic                  hsync_out, vsync_out;

    step_t            steps[$];
    scr_pkg::screen_e m_state = scr_pkg::SCR_MENU;   // reference model registers
    logic             m_diff  = 1'b0;
    scr_pkg::theme_t  m_theme = '0;
    int unsigned      lcg_state = 32'd77;
    int               cycles = 0;
    int               cycle_limit = 0;

    tb_clkgen clkgen0 (.clk(clk), .rst(rst));

    screen_ctl dut0 (
        .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount),
        .hsync(hsync), .vsync(vsync), .hblnk(hblnk), .vblnk(vblnk),
        .xpos(xpos), .ypos(ypos), .mouse_left(mouse_left), .button(button),
        .rgb_out(rgb_out), .hsync_out(hsync_out), .vsync_out(vsync_out)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic in_box(input int x, y, x0, x1, y0, y1);
        return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);   // bounds inclusive
    endfunction

    function automatic logic [23:0] palette(input scr_pkg::theme_t th);
        case (th)                 // {background, accent}
            3'd0: return 24'h000FFF;
            3'd1: return 24'h099F66;
            3'd2: return 24'h9096F6;
            3'd3: return 24'h99066F;
            3'd4: return 24'h009FF6;
            3'd5: return 24'h9006FF;
            default: return 24'h090F6F;
        endcase
    endfunction

    function automatic scr_pkg::rgb_t pixel_exp(input scr_pkg::screen_e scr,
            input scr_pkg::theme_t th, input logic diff, input int h, v, input logic blank);
        logic [23:0] pal;
        logic        on_btn, on_frame;
        pal = palette(th);
        on_btn = in_box(h, v, `BTN_X_MIN, `BTN_X_MAX, `DIFF_Y_MIN, `DIFF_Y_MAX) ||
                 in_box(h, v, `BTN_X_MIN, `BTN_X_MAX, `THEME_Y_MIN, `THEME_Y_MAX) ||
                 in_box(h, v, `BTN_X_MIN, `BTN_X_MAX, `CRED_Y_MIN, `CRED_Y_MAX) ||
                 (diff && in_box(h, v, `MARK_X_MIN, `MARK_X_MAX, `MARK_Y_MIN, `MARK_Y_MAX));
        on_frame = !in_box(h, v, `FRAME_W, `SCR_H_ACT - 1 - `FRAME_W,
                           `FRAME_W, `SCR_V_ACT - 1 - `FRAME_W);   // outside the inner panel
        if (blank)
            return '0;
        if (scr == scr_pkg::SCR_CREDITS)
            return on_frame ? pal[11:0] : pal[23:12];
        return on_btn ? pal[11:0] : pal[23:12];
    endfunction

    // adds one table row and steps the model with its click
    task automatic add_step(input int h, v, input logic hb, vb, input int x, y,
            input logic click, btn);
        step_t           s;
        scr_pkg::theme_t col_theme;
        logic            col_diff;
        int unsigned     r;
        col_theme = m_theme;      // colours lag the registers by one cycle
        col_diff  = m_diff;
        r = lcg_next();
        if (m_state == scr_pkg::SCR_MENU) begin
            if (click && in_box(x, y, `BTN_X_MIN, `BTN_X_MAX, `CRED_Y_MIN, `CRED_Y_MAX))
                m_state = scr_pkg::SCR_CREDITS;
            if (click && in_box(x, y, `BTN_X_MIN, `BTN_X_MAX, `DIFF_Y_MIN, `DIFF_Y_MAX))
                m_diff = !m_diff;
            if (click && in_box(x, y, `BTN_X_MIN, `BTN_X_MAX, `THEME_Y_MIN, `THEME_Y_MAX))
                m_theme = (m_theme + 1) % 7;       // seven palette entries
        end else if (btn) begin
            m_state = scr_pkg::SCR_MENU;
        end
        s.h = h;
        s.v = v;
        s.hb = hb;
        s.vb = vb;
        s.hs = r[20];                              // random sync pattern
        s.vs = r[27];
        s.x = x;
        s.y = y;
        s.click = click;
        s.btn = btn;
        s.exp_rgb = pixel_exp(m_state, col_theme, col_diff, h, v, hb || vb);
        steps.push_back(s);
    endtask

    task automatic add_pixel(input int h, v);
        add_step(h, v, 1'b0, 1'b0, 0, 0, 1'b0, 1'b0);
    endtask

    task automatic add_click(input int x, y);
        add_step(x, y, 1'b0, 1'b0, x, y, 1'b1, 1'b0);   // pointer pixel drawn too
    endtask

    task automatic add_sweep(input int n);
        int unsigned r;
        for (int k = 0; k < n; k++) begin
            r = lcg_next();
            add_step((r >> 8) % `SCR_H_ACT, (r >> 4) % `SCR_V_ACT, (r >> 29) == 0, 1'b0,
                     0, 0, 1'b0, 1'b0);
        end
    endtask

    task automatic build_table();
        add_sweep(24);                          // theme 0 menu
        add_pixel(400, 250);
        add_pixel(600, 500);
        add_pixel(362, 722);
        add_pixel(361, 622);                    // just left of the column
        add_pixel(320, 288);                    // marker unlit
        add_step(500, 280, 1'b0, 1'b1, 0, 0, 1'b0, 1'b0);
        add_click(500, 280);                    // difficulty on
        add_pixel(320, 288);
        add_pixel(300, 268);
        add_click(362, 238);                    // and off again
        add_pixel(340, 308);
        for (int k = 0; k < 8; k++) begin       // themes 1..6, 0, 1
            add_click(674, 430 + k * 12);
            add_pixel(100, 100);
            add_pixel(500, 500);
        end
        add_click(500, 300);                    // difficulty left on
        add_click(500, 700);                    // to credits
        add_sweep(24);
        add_pixel(0, 400);
        add_pixel(1023, 300);
        add_pixel(7, 7);
        add_pixel(8, 8);
        add_pixel(500, 767);
        add_pixel(1015, 759);
        add_step(500, 400, 1'b0, 1'b1, 0, 0, 1'b0, 1'b0);   // blanked on credits
        add_click(500, 280);                    // ignored on credits
        add_click(500, 480);
        add_click(500, 700);
        add_pixel(500, 20);
        add_pixel(3, 500);
        add_step(500, 100, 1'b0, 1'b0, 0, 0, 1'b0, 1'b1);   // back to menu
        add_pixel(320, 288);
        add_pixel(500, 500);
        add_pixel(100, 100);
        add_sweep(8);
    endtask

    task automatic drive_step(input step_t s);
        hcount = s.h;
        vcount = s.v;
        hsync = s.hs;
        vsync = s.vs;
        hblnk = s.hb;
        vblnk = s.vb;
        xpos = s.x;
        ypos = s.y;
        mouse_left = s.click;
        button = s.btn;
    endtask

    task automatic drive_idle();
        hcount = '0;
        vcount = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        hblnk = 1'b1;                           // blanked with no pointer action
        vblnk = 1'b1;
        xpos = '0;
        ypos = '0;
        mouse_left = 1'b0;
        button = 1'b0;
    endtask

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_rgb(input scr_pkg::rgb_t got, exp, input int idx);
        if (got !== exp)
            fail_now($sformatf("[ERROR] %0t: rgb_out at step %0d is %h, expected %h",
                               $time, idx, got, exp));
    endtask

    task automatic check_sync(input logic hs_got, vs_got, hs_exp, vs_exp, input int idx);
        if (hs_got !== hs_exp || vs_got !== vs_exp)
            fail_now($sformatf("[ERROR] %0t: hsync/vsync at step %0d are %b/%b, expected %b/%b",
                               $time, idx, hs_got, vs_got, hs_exp, vs_exp));
    endtask

    // run limit from table length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
            fail_now($sformatf("Timeout: run did not finish within %0d clock cycles",
                               cycle_limit));
    end

    initial begin
        drive_idle();
        build_table();
        cycle_limit = steps.size() * 4 + 100;
        @(negedge rst);
        check_rgb(rgb_out, '0, -1);             // reset values
        check_sync(hsync_out, vsync_out, 1'b0, 1'b0, -1);
        for (int i = 0; i < steps.size() + 2; i++) begin
            @(posedge clk);
            #2;
            if (i >= 2) begin                   // fixed 2 cycle latency
                check_rgb(rgb_out, steps[i-2].exp_rgb, i - 2);
                check_sync(hsync_out, vsync_out, steps[i-2].hs, steps[i-2].vs, i - 2);
            end
            if (i < steps.size())
                drive_step(steps[i]);
            else
                drive_idle();
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/scr_pkg.sv
source/menu_render.sv
source/cred_render.sv
source/screen_ctl.sv
verif/tb_clkgen.sv
verif/screen_tb.sv

/* Bender.yml */
package:
  name: screen_ctl

sources:
  - include_dirs:
      - source
    files:
      - source/scr_pkg.sv
      - source/menu_render.sv
      - source/cred_render.sv
      - source/screen_ctl.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clkgen.sv
      - verif/screen_tb.sv
